// ==== compile.f ====
+incdir+logic
logic/fcb_spis_pkg.sv
logic/spis_frame_rx.sv
logic/spis_cmd_fifo.sv
logic/spis_dispatch.sv
logic/fcb_spis_top.sv
testbench/fcb_spis_tb.sv

// ==== Bender.yml ====
package:
  name: fcb_spis

export_include_dirs:
  - logic

sources:
  - logic/fcb_spis_pkg.sv
  - logic/spis_frame_rx.sv
  - logic/spis_cmd_fifo.sv
  - logic/spis_dispatch.sv
  - logic/fcb_spis_top.sv
  - target: test
    files:
      - testbench/fcb_spis_tb.sv

// ==== testbench/fcb_spis_tb.sv ====
/*
 * Directed testbench of the SPI slave configuration port
 * SPI host tasks, Wishbone slave and SFR read models, compare tasks
 */

`timescale 1ns/1ps
`default_nettype none
`include "fcb_spis_settings.svh"

module fcb_spis_tb;
  import fcb_spis_pkg::*;

  localparam int PHASE_CLKS     = 4;                     // Clocks per SCLK phase
  localparam int TIMEOUT_CYCLES = 20000;  // 16 frames of 140 clocks plus quiet time, wide margin

  logic        fcb_spis_clk;
  logic        fcb_spis_rst_n;
  logic        spi_sclk;
  logic        spi_cs_n;
  logic        spi_mosi;
  logic        spi_miso;
  logic        spi_miso_en;
  logic        spi_mode_en;
  logic        spi_master_en;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  spis_addr_t  wb_adr;
  spis_data_t  wb_dat_o;
  logic        wb_ack;
  logic        cwf_wr_en;
  spis_data_t  cwf_wr_data;
  logic        cwf_full;
  spis_addr_t  sfr_rd_addr;
  spis_data_t  sfr_rd_data;
  logic        overflow;

  spis_entry_t delivered[$];        // Writes seen on either route, in order
  int          cwf_count;
  int          cycles;
  logic        ack_hold;            // Wishbone ack withheld
  int          ack_delay;

  fcb_spis_top DUT (.*);

  always #4 fcb_spis_clk = ~fcb_spis_clk;

  // SFR read model
  assign sfr_rd_data = {1'b0, sfr_rd_addr} ^ 8'h5A;

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "Bit mismatch");
    end
  endtask

  task automatic check_data(input string name, input spis_data_t exp, input spis_data_t act);
    if (act !== exp)
    begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic check_entry(input string name, input spis_entry_t exp, input spis_entry_t act);
    if (act !== exp)
    begin
      $display("Fail %s: expected %h/%h, actual %h/%h", name, exp.addr, exp.data,
               act.addr, act.data);
      $display("Simulation failed");
      $fatal(1, "Entry mismatch");
    end
  endtask

  // Wishbone slave model, ack after 0 to 3 cycles
  always
  begin
    @(posedge fcb_spis_clk);
    #1;
    if (wb_cyc && wb_stb && !ack_hold)
    begin
      ack_delay = $urandom % 4;
      repeat (ack_delay)
      begin
        @(posedge fcb_spis_clk);
        #1;
      end
      check_bit("wb_we on write cycle", 1'b1, wb_we);
      delivered.push_back('{addr: wb_adr, data: wb_dat_o});
      wb_ack = 1'b1;
      @(posedge fcb_spis_clk);
      #1;
      wb_ack = 1'b0;                // Single-cycle ack
    end
  end

  // Configuration port monitor, mid-cycle sample
  always @(negedge fcb_spis_clk)
  begin
    if (cwf_wr_en)
    begin
      check_bit("cwf_wr_en with cwf_full high", 1'b0, cwf_full);
      delivered.push_back('{addr: `FCB_SPIS_CWF_ADDR, data: cwf_wr_data});
      cwf_count++;
    end
  end

  always @(posedge fcb_spis_clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: DUT did not deliver the expected writes in time");
      $display("Simulation failed");
      $fatal(1, "Timeout");
    end
  end

  task automatic wait_clks(input int n);
    repeat (n) @(posedge fcb_spis_clk);
    #1;                             // Drive point after the edge
  endtask

  task automatic wait_delivered(input int n);
    while (delivered.size() < n)
      wait_clks(1);
  endtask

  task automatic spi_xfer(input spis_data_t cmd, input spis_data_t wdata,
                          output spis_data_t rdata, output logic en_seen);
    logic [15:0] tx;
    tx       = {cmd, wdata};
    rdata    = '0;
    en_seen  = 1'b0;
    spi_cs_n = 1'b0;
    wait_clks(PHASE_CLKS);          // CS setup
    for (int i = 15; i >= 0; i--)
    begin
      spi_mosi = tx[i];
      wait_clks(PHASE_CLKS);        // Low phase
      if (i < 8)
        rdata[i] = spi_miso;        // Shifted on the previous fall
      if (i == 7)
        en_seen = spi_miso_en;
      spi_sclk = 1'b1;
      wait_clks(PHASE_CLKS);
      spi_sclk = 1'b0;
    end
    wait_clks(PHASE_CLKS);
    spi_cs_n = 1'b1;
    wait_clks(PHASE_CLKS);          // Frame end seen by the DUT
  endtask

  task automatic spi_write(input spis_addr_t addr, input spis_data_t data, output logic en_seen);
    spis_data_t unused;
    spi_xfer({1'b1, addr}, data, unused, en_seen);
  endtask

  task automatic spi_read(input spis_addr_t addr, output spis_data_t data, output logic en_seen);
    spi_xfer({1'b0, addr}, 8'h00, data, en_seen);
  endtask

  task automatic expect_next(input string name, input spis_addr_t addr, input spis_data_t data);
    spis_entry_t got;
    got = delivered.pop_front();
    check_entry(name, '{addr: addr, data: data}, got);
  endtask

  task automatic test_sfr_writes();
    spis_addr_t addrs [3] = '{7'h05, 7'h41, 7'h7F};
    spis_data_t datas [3] = '{8'h3C, 8'hA7, 8'h18};
    logic       en;
    for (int k = 0; k < 3; k++)
      spi_write(addrs[k], datas[k], en);
    wait_delivered(3);
    for (int k = 0; k < 3; k++)
      expect_next("sfr_writes", addrs[k], datas[k]);
  endtask

  task automatic test_cwf_write();
    logic en;
    spi_write(`FCB_SPIS_CWF_ADDR, 8'h96, en);
    wait_delivered(1);
    wait_clks(20);                  // Quiet period, no second pulse
    check_data("cwf_write pulse count", 8'd1, spis_data_t'(cwf_count));
    check_data("cwf_write entry count", 8'd1, spis_data_t'(delivered.size()));
    expect_next("cwf_write", `FCB_SPIS_CWF_ADDR, 8'h96);
    cwf_count = 0;
  endtask

  task automatic test_sfr_read();
    spis_data_t rd;
    logic       en;
    spi_read(7'h33, rd, en);
    check_data("sfr_read data", 8'h33 ^ 8'h5A, rd);
    check_bit("sfr_read miso_en", 1'b1, en);
    wait_clks(20);
    check_data("sfr_read no write", 8'd0, spis_data_t'(delivered.size()));
  endtask

  task automatic test_cwf_backpressure();
    logic en;
    cwf_full = 1'b1;
    spi_write(`FCB_SPIS_CWF_ADDR, 8'h11, en);
    spi_write(7'h0A, 8'h22, en);
    spi_write(`FCB_SPIS_CWF_ADDR, 8'h33, en);
    wait_clks(20);
    check_data("backpressure stalled", 8'd0, spis_data_t'(delivered.size()));
    cwf_full = 1'b0;
    wait_delivered(3);
    expect_next("backpressure 0", `FCB_SPIS_CWF_ADDR, 8'h11);
    expect_next("backpressure 1", 7'h0A, 8'h22);
    expect_next("backpressure 2", `FCB_SPIS_CWF_ADDR, 8'h33);
  endtask

  task automatic test_slave_off();
    logic en;
    spi_master_en = 1'b1;           // Master mode turns the slave off
    wait_clks(PHASE_CLKS);
    spi_write(7'h12, 8'h5E, en);
    check_bit("slave_off master miso_en", 1'b0, en);
    spi_master_en = 1'b0;
    spi_mode_en   = 1'b0;           // SPI mode off
    wait_clks(PHASE_CLKS);
    spi_write(7'h13, 8'h6F, en);
    check_bit("slave_off mode miso_en", 1'b0, en);
    wait_clks(20);
    check_data("slave_off bus activity", 8'd0, spis_data_t'(delivered.size()));
    spi_mode_en = 1'b1;
    wait_clks(PHASE_CLKS);
  endtask

  task automatic test_fifo_overflow();
    localparam int N = `FCB_SPIS_FIFO_DEPTH + 2;
    logic en;
    check_bit("overflow before fill", 1'b0, overflow);
    ack_hold = 1'b1;
    for (int k = 0; k < N; k++)
      spi_write(spis_addr_t'(k + 1), spis_data_t'(8'hC0 + k), en);
    wait_clks(10);
    check_bit("overflow set", 1'b1, overflow);
    check_data("overflow held", 8'd0, spis_data_t'(delivered.size()));
    ack_hold = 1'b0;
    wait_delivered(N - 1);          // One in the bus registers, DEPTH in the FIFO
    for (int k = 0; k < N - 1; k++)
      expect_next("overflow order", spis_addr_t'(k + 1), spis_data_t'(8'hC0 + k));
    wait_clks(40);
    check_data("overflow dropped", 8'd0, spis_data_t'(delivered.size()));
  endtask

  initial
  begin
    void'($urandom(32'hfd53b783));
    fcb_spis_clk   = 1'b0;
    fcb_spis_rst_n = 1'b0;
    spi_sclk       = 1'b0;
    spi_cs_n       = 1'b1;
    spi_mosi       = 1'b0;
    spi_mode_en    = 1'b1;
    spi_master_en  = 1'b0;
    wb_ack         = 1'b0;
    cwf_full       = 1'b0;
    ack_hold       = 1'b0;
    cwf_count      = 0;
    cycles         = 0;
    wait_clks(4);                   // Reset for 4 cycles
    check_bit("reset wb_cyc", 1'b0, wb_cyc);
    check_bit("reset wb_stb", 1'b0, wb_stb);
    check_bit("reset wb_we", 1'b0, wb_we);
    check_bit("reset cwf_wr_en", 1'b0, cwf_wr_en);
    check_bit("reset miso_en", 1'b0, spi_miso_en);
    check_bit("reset overflow", 1'b0, overflow);
    fcb_spis_rst_n = 1'b1;
    wait_clks(4);
    test_sfr_writes();
    test_cwf_write();
    test_sfr_read();
    test_cwf_backpressure();
    test_slave_off();
    test_fifo_overflow();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/fcb_spis_top.sv ====
/*
 * SPI slave configuration port top level
 * Frame receiver, command FIFO and dispatcher
 */

`timescale 1ns/1ps
`default_nettype none

module fcb_spis_top (
  input  logic                     fcb_spis_clk,
  input  logic                     fcb_spis_rst_n,
  input  logic                     spi_sclk,
  input  logic                     spi_cs_n,
  input  logic                     spi_mosi,
  output logic                     spi_miso,
  output logic                     spi_miso_en,
  input  logic                     spi_mode_en,
  input  logic                     spi_master_en,
  output logic                     wb_cyc,
  output logic                     wb_stb,
  output logic                     wb_we,
  output fcb_spis_pkg::spis_addr_t wb_adr,
  output fcb_spis_pkg::spis_data_t wb_dat_o,
  input  logic                     wb_ack,
  output logic                     cwf_wr_en,
  output fcb_spis_pkg::spis_data_t cwf_wr_data,
  input  logic                     cwf_full,
  output fcb_spis_pkg::spis_addr_t sfr_rd_addr,
  input  fcb_spis_pkg::spis_data_t sfr_rd_data,
  output logic                     overflow
);
  import fcb_spis_pkg::*;

  logic        push;                // Write frame done
  spis_entry_t push_entry;
  logic        pop;
  spis_entry_t pop_entry;           // FIFO head
  logic        empty;

  spis_frame_rx u_frame_rx (
    .fcb_spis_clk   (fcb_spis_clk),
    .fcb_spis_rst_n (fcb_spis_rst_n),
    .spi_sclk       (spi_sclk),
    .spi_cs_n       (spi_cs_n),
    .spi_mosi       (spi_mosi),
    .spi_mode_en    (spi_mode_en),
    .spi_master_en  (spi_master_en),
    .sfr_rd_data    (sfr_rd_data),
    .spi_miso       (spi_miso),
    .spi_miso_en    (spi_miso_en),
    .sfr_rd_addr    (sfr_rd_addr),
    .push           (push),
    .push_entry     (push_entry)
  );

  spis_cmd_fifo u_cmd_fifo (
    .fcb_spis_clk   (fcb_spis_clk),
    .fcb_spis_rst_n (fcb_spis_rst_n),
    .push           (push),
    .push_entry     (push_entry),
    .pop            (pop),
    .pop_entry      (pop_entry),
    .empty          (empty),
    .overflow       (overflow)
  );

  spis_dispatch u_dispatch (
    .fcb_spis_clk   (fcb_spis_clk),
    .fcb_spis_rst_n (fcb_spis_rst_n),
    .empty          (empty),
    .pop_entry      (pop_entry),
    .wb_ack         (wb_ack),
    .cwf_full       (cwf_full),
    .pop            (pop),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_o       (wb_dat_o),
    .cwf_wr_en      (cwf_wr_en),
    .cwf_wr_data    (cwf_wr_data)
  );

endmodule

`default_nettype wire

// ==== logic/spis_dispatch.sv ====
/*
 * Dispatcher FSM draining the command FIFO
 * Wishbone classic writes to SFRs, or configuration write port
 */

`timescale 1ns/1ps
`default_nettype none
`include "fcb_spis_settings.svh"

module spis_dispatch (
  input  logic                      fcb_spis_clk,
  input  logic                      fcb_spis_rst_n,
  input  logic                      empty,
  input  fcb_spis_pkg::spis_entry_t pop_entry,
  input  logic                      wb_ack,
  input  logic                      cwf_full,
  output logic                      pop,
  output logic                      wb_cyc,
  output logic                      wb_stb,
  output logic                      wb_we,
  output fcb_spis_pkg::spis_addr_t  wb_adr,
  output fcb_spis_pkg::spis_data_t  wb_dat_o,
  output logic                      cwf_wr_en,
  output fcb_spis_pkg::spis_data_t  cwf_wr_data
);
  import fcb_spis_pkg::*;

  dispatch_state_t state;
  dispatch_state_t state_nx;
  spis_addr_t      adr_q;           // Held for the whole bus cycle
  spis_data_t      dat_q;
  logic            is_cwf;          // Head targets the config stream
  logic            wb_load;

  assign is_cwf  = (pop_entry.addr == `FCB_SPIS_CWF_ADDR);
  assign wb_load = (state == DSP_IDLE) && !empty && !is_cwf;

  always_comb
  begin
    state_nx  = state;
    pop       = 1'b0;
    cwf_wr_en = 1'b0;
    unique case (state)
      DSP_IDLE:
      begin
        if (!empty)
        begin
          if (is_cwf)
            state_nx = DSP_CWF;
          else
          begin
            state_nx = DSP_WB;
            pop      = 1'b1;        // Head copied into bus registers
          end
        end
      end
      DSP_WB:
      begin
        if (wb_ack)
          state_nx = DSP_IDLE;      // Bus drops next cycle
      end
      DSP_CWF:
      begin
        if (!cwf_full)
        begin
          cwf_wr_en = 1'b1;
          pop       = 1'b1;
          state_nx  = DSP_IDLE;
        end
      end
      default: state_nx = DSP_IDLE;
    endcase
  end

  always_ff @(posedge fcb_spis_clk or negedge fcb_spis_rst_n)
  begin
    if (!fcb_spis_rst_n)
      state <= DSP_IDLE;
    else
      state <= state_nx;
  end

  always_ff @(posedge fcb_spis_clk)
  begin
    if (wb_load)
    begin
      adr_q <= pop_entry.addr;
      dat_q <= pop_entry.data;
    end
  end

  // Classic write cycle, all strobes from one state
  assign wb_cyc      = (state == DSP_WB);
  assign wb_stb      = (state == DSP_WB);
  assign wb_we       = (state == DSP_WB);
  assign wb_adr      = adr_q;
  assign wb_dat_o    = dat_q;
  assign cwf_wr_data = pop_entry.data;   // Head stays until the pop

endmodule

`default_nettype wire

// ==== logic/spis_cmd_fifo.sv ====
/*
 * Synchronous command FIFO of write entries
 * Full drops the push and sets a sticky overflow flag
 */

`timescale 1ns/1ps
`default_nettype none
`include "fcb_spis_settings.svh"

module spis_cmd_fifo (
  input  logic                      fcb_spis_clk,
  input  logic                      fcb_spis_rst_n,
  input  logic                      push,
  input  fcb_spis_pkg::spis_entry_t push_entry,
  input  logic                      pop,
  output fcb_spis_pkg::spis_entry_t pop_entry,
  output logic                      empty,
  output logic                      overflow
);
  import fcb_spis_pkg::*;

  localparam int DEPTH = `FCB_SPIS_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  spis_entry_t      mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;          // Occupancy
  logic             full;
  logic             do_push;
  logic             do_pop;

  // Pointer wrap at DEPTH, not a power of two in general
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full      = (count == CNT_W'(DEPTH));
  assign empty     = (count == '0);
  assign do_push   = push & ~full;
  assign do_pop    = pop & ~empty;
  assign pop_entry = mem[rd_ptr];   // Head entry

  always_ff @(posedge fcb_spis_clk or negedge fcb_spis_rst_n)
  begin
    if (!fcb_spis_rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_next(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_next(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;    // Both or neither
      endcase
      if (push && full)
        overflow <= 1'b1;           // Sticky until reset
    end
  end

  // Storage
  always_ff @(posedge fcb_spis_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_entry;
  end

endmodule

`default_nettype wire

// ==== logic/spis_frame_rx.sv ====
/*
 * SPI mode 0 frame receiver, SCLK oversampled on the system clock
 * Command decode, write entry push and MISO read shifter
 */

`timescale 1ns/1ps
`default_nettype none
`include "fcb_spis_settings.svh"

module spis_frame_rx (
  input  logic                      fcb_spis_clk,
  input  logic                      fcb_spis_rst_n,
  input  logic                      spi_sclk,
  input  logic                      spi_cs_n,
  input  logic                      spi_mosi,
  input  logic                      spi_mode_en,
  input  logic                      spi_master_en,
  input  fcb_spis_pkg::spis_data_t  sfr_rd_data,
  output logic                      spi_miso,
  output logic                      spi_miso_en,
  output fcb_spis_pkg::spis_addr_t  sfr_rd_addr,
  output logic                      push,
  output fcb_spis_pkg::spis_entry_t push_entry
);
  import fcb_spis_pkg::*;

  localparam int SYNC_N = `FCB_SPIS_SYNC_STAGES;

  // Pin group moving through the synchroniser together
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  localparam spi_pins_t PINS_IDLE = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0};

  logic       spis_on;              // Slave enabled
  spi_pins_t  pins_qf;              // Pins after chip-select qualification
  spi_pins_t  pins_sync [SYNC_N];
  spi_pins_t  pins_q;               // Synchronised pins
  logic       sclk_d;               // Previous synchronised SCLK
  logic       sclk_rise;
  logic       sclk_fall;
  logic       frame_act;            // Chip select low
  logic [4:0] bit_cnt;              // Rising edges in this frame, stops at 16
  spis_data_t shift_in;
  spis_data_t byte_in;              // Byte including the bit now sampled
  logic       cmd_wr;               // Command bit 7
  spis_addr_t cmd_addr;
  spis_data_t rd_data_q;            // SFR read byte, one clock late
  spis_data_t miso_sr;

  // On only in SPI mode with master mode off
  assign spis_on = spi_mode_en & ~spi_master_en;

  assign pins_qf.sclk = spi_sclk;
  assign pins_qf.cs_n = spis_on ? spi_cs_n : 1'b1;   // Forced inactive when off
  assign pins_qf.mosi = spi_mosi;

  assign pins_q    = pins_sync[SYNC_N-1];
  assign sclk_rise = pins_q.sclk & ~sclk_d;
  assign sclk_fall = ~pins_q.sclk & sclk_d;
  assign frame_act = ~pins_q.cs_n;
  assign byte_in   = {shift_in[6:0], pins_q.mosi};   // MSB first

  assign sfr_rd_addr = cmd_addr;    // Stable from command end to frame end
  assign spi_miso    = miso_sr[7];

  // Pin synchroniser and SCLK history
  always_ff @(posedge fcb_spis_clk or negedge fcb_spis_rst_n)
  begin
    if (!fcb_spis_rst_n)
    begin
      for (int i = 0; i < SYNC_N; i++)
      begin
        pins_sync[i] <= PINS_IDLE;
      end
      sclk_d <= 1'b0;
    end
    else
    begin
      pins_sync[0] <= pins_qf;
      for (int i = 1; i < SYNC_N; i++)
      begin
        pins_sync[i] <= pins_sync[i-1];
      end
      sclk_d <= pins_q.sclk;
    end
  end

  // Bit count, command latch, push strobe, MISO shifter
  always_ff @(posedge fcb_spis_clk or negedge fcb_spis_rst_n)
  begin
    if (!fcb_spis_rst_n)
    begin
      bit_cnt     <= '0;
      cmd_wr      <= 1'b0;
      cmd_addr    <= '0;
      push        <= 1'b0;
      miso_sr     <= '0;
      spi_miso_en <= 1'b0;
    end
    else
    begin
      push        <= 1'b0;
      spi_miso_en <= spis_on;
      if (!frame_act)
      begin
        bit_cnt <= '0;              // CS high ends the frame
      end
      else
      begin
        if (sclk_rise && bit_cnt != 5'd16)
        begin
          bit_cnt <= bit_cnt + 5'd1;
          if (bit_cnt == 5'd7)
          begin
            cmd_wr   <= byte_in[7];
            cmd_addr <= byte_in[6:0];
          end
          if (bit_cnt == 5'd15)
          begin
            push <= cmd_wr;         // Reads push nothing
          end
        end
        if (sclk_fall)
        begin
          if (bit_cnt == 5'd8)
            miso_sr <= rd_data_q;   // First fall after command bit 0
          else
            miso_sr <= {miso_sr[6:0], 1'b0};
        end
      end
    end
  end

  // Payload path
  always_ff @(posedge fcb_spis_clk)
  begin
    rd_data_q <= sfr_rd_data;
    if (frame_act && sclk_rise)
    begin
      shift_in <= byte_in;
      if (bit_cnt == 5'd15)
        push_entry <= '{addr: cmd_addr, data: byte_in};
    end
  end

endmodule

`default_nettype wire

// ==== logic/fcb_spis_pkg.sv ====
/*
 * Shared types of the SPI slave configuration port
 * Address, data and FIFO entry types, dispatcher FSM states
 */

`default_nettype none

package fcb_spis_pkg;

  // SFR register address, low seven bits of the command byte
  typedef logic [6:0] spis_addr_t;

  // Data byte, MOSI second byte or MISO read byte
  typedef logic [7:0] spis_data_t;

  // One buffered write
  typedef struct packed {
    spis_addr_t addr;
    spis_data_t data;
  } spis_entry_t;

  // Dispatcher FSM
  typedef enum logic [1:0] {
    DSP_IDLE, DSP_WB, DSP_CWF
  } dispatch_state_t;

endpackage

`default_nettype wire

// ==== logic/fcb_spis_settings.svh ====
/*
 * Build-time constants of the SPI slave configuration port
 * FIFO depth, pin synchroniser depth, configuration-stream address
 */

`ifndef FCB_SPIS_SETTINGS_SVH
`define FCB_SPIS_SETTINGS_SVH

// Write entries buffered between SPI frames and the dispatcher
`define FCB_SPIS_FIFO_DEPTH 4

// Flops per pin before the SCLK edge detector
`define FCB_SPIS_SYNC_STAGES 2

// Writes to this address feed the configuration write port
`define FCB_SPIS_CWF_ADDR 7'h20

`endif
